/* filelist.f */
+incdir+logic
+incdir+testbench
logic/pluckSynthPkg.sv
logic/keyControl.sv
logic/noiseSource.sv
logic/delayLine.sv
logic/stringVoice.sv
logic/voiceMixer.sv
logic/pluckedStringSynth.sv
testbench/tbPluckedString.sv

/* logic/delayLine.sv */
`default_nettype none

`include "pluckSynth_macros.svh"

module delayLine
	import pluckSynthPkg::*;
#(
	parameter int unsigned delayLength = 243  // Samples in the loop
)
(
	input  wire          CLOCK_50,
	input  wire          rstN,
	input  wire          sampleTick,
	input  wire sample_t writeData,  // Replaces the entry at the pointer
	output sample_t      readData    // Entry at the pointer
);

	sample_t               mem [delayLength];
	logic [`PTR_WIDTH-1:0] ptr;

	assign readData = mem[ptr];  // Async read

	// Wrapping pointer
	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
			ptr <= '0;
		else if (sampleTick)
			ptr <= (ptr == `PTR_WIDTH'(delayLength - 1)) ? '0 : ptr + 1'b1;
	end

	// Sample storage
	always_ff @(posedge CLOCK_50)
	begin
		if (sampleTick)
			mem[ptr] <= writeData;
	end

endmodule

`default_nettype wire

/* logic/keyControl.sv */
`default_nettype none

`include "pluckSynth_macros.svh"

module keyControl
	import pluckSynthPkg::*;
(
	input  wire                              CLOCK_50,
	input  wire                              rstN,
	input  wire  [`NUM_STRINGS-1:0]          keys,       // Raw async levels
	output stringCtrl_t [`NUM_STRINGS-1:0]   stringCtrl  // One bundle per voice
);

	logic [`NUM_STRINGS-1:0] keyMeta;  // First sync stage
	logic [`NUM_STRINGS-1:0] keySync;  // Safe to use

	////////////////////
	// Two-flop sync then edge detect
	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			keyMeta    <= '0;
			keySync    <= '0;
			stringCtrl <= '0;
		end
		else
		begin
			keyMeta <= keys;
			keySync <= keyMeta;
			for (int i = 0; i < `NUM_STRINGS; i++)
			begin
				// Old sustain doubles as the previous level
				stringCtrl[i].pluck   <= keySync[i] & ~stringCtrl[i].sustain;
				stringCtrl[i].sustain <= keySync[i];  // Picks the loss gain
			end
		end
	end

endmodule

`default_nettype wire

/* logic/noiseSource.sv */
`default_nettype none

`include "pluckSynth_macros.svh"

module noiseSource
	import pluckSynthPkg::*;
(
	input  wire     CLOCK_50,
	input  wire     rstN,
	input  wire     sampleTick,  // Steps the sequence
	output sample_t noise        // Shared by every voice
);

	logic [`SAMPLE_WIDTH-1:0] lfsr;
	logic                     feedback;

	// Taps 17 and 10 for the 18-bit Fibonacci form
	assign feedback = lfsr[`SAMPLE_WIDTH-1] ^ lfsr[10];

	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
			lfsr <= `LFSR_SEED;
		else if (sampleTick)
			lfsr <= {lfsr[`SAMPLE_WIDTH-2:0], feedback};  // Shift left
	end

	// Voices sample this at the tick edge, so they see the pre-step value
	assign noise = sample_t'(lfsr);

endmodule

`default_nettype wire

/* logic/pluckSynthPkg.sv */
`default_nettype none

`include "pluckSynth_macros.svh"

package pluckSynthPkg;

	// One audio sample in 2.16
	typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

	// Control bundle for one string
	typedef struct packed {
		logic pluck;    // Single cycle on key press
		logic sustain;  // Synchronized key level
	} stringCtrl_t;

	// Delay lengths in samples per string
	// Shorter line gives higher pitch
	parameter int unsigned noteLengthTable [`NUM_STRINGS] = '{
		243,
		230,
		231,
		218,
		206,
		194,
		183,
		173
	};

endpackage

`default_nettype wire

/* logic/pluckSynth_macros.svh */
`ifndef PLUCKSYNTH_MACROS_SVH
`define PLUCKSYNTH_MACROS_SVH

////////////////////
// Voice bank size and sample format
`define NUM_STRINGS   8
`define SAMPLE_WIDTH  18          // 2.16 signed
`define PTR_WIDTH     8           // Longest note is 243 samples

////////////////////
// Loss filter gains in 2.16
`define GAIN_SUSTAIN  18'h07FC0   // Key held
`define GAIN_DAMP     18'h07DA4   // Key released so the ring dies sooner

// Mixer headroom bits, log2 of NUM_STRINGS
`define MIX_SHIFT     3

////////////////////
// Excitation noise
`define LFSR_SEED     18'h2A5F3   // Any nonzero state works
`define NOISE_SHIFT   2           // Burst level relative to full scale

`endif

/* logic/pluckedStringSynth.sv */
`default_nettype none

`include "pluckSynth_macros.svh"

module pluckedStringSynth
	import pluckSynthPkg::*;
(
	input  wire                      CLOCK_50,
	input  wire                      rstN,
	input  wire [`NUM_STRINGS-1:0]   keys,        // One key per string
	input  wire                      sampleTick,  // Audio rate strobe
	output sample_t                  mixSample,
	output logic                     mixValid     // Two cycles after the tick
);

	stringCtrl_t [`NUM_STRINGS-1:0] stringCtrl;
	sample_t                        noise;
	sample_t [`NUM_STRINGS-1:0]     voiceOut;

	////////////////////
	// Shared control and excitation
	keyControl i_keyControl (
		.CLOCK_50   (CLOCK_50),
		.rstN       (rstN),
		.keys       (keys),
		.stringCtrl (stringCtrl)
	);

	noiseSource i_noiseSource (
		.CLOCK_50   (CLOCK_50),
		.rstN       (rstN),
		.sampleTick (sampleTick),
		.noise      (noise)
	);

	////////////////////
	// String bank with pitch from the note table
	for (genvar i = 0; i < `NUM_STRINGS; i++)
	begin : g_voice
		stringVoice #(
			.delayLength (noteLengthTable[i])
		) i_stringVoice (
			.CLOCK_50   (CLOCK_50),
			.rstN       (rstN),
			.sampleTick (sampleTick),
			.stringCtrl (stringCtrl[i]),
			.noise      (noise),
			.voiceOut   (voiceOut[i])
		);
	end

	voiceMixer i_voiceMixer (
		.CLOCK_50   (CLOCK_50),
		.rstN       (rstN),
		.sampleTick (sampleTick),
		.voiceOut   (voiceOut),
		.mixSample  (mixSample),
		.mixValid   (mixValid)
	);

endmodule

`default_nettype wire

/* logic/stringVoice.sv */
`default_nettype none

`include "pluckSynth_macros.svh"

module stringVoice
	import pluckSynthPkg::*;
#(
	parameter int unsigned delayLength = 243  // Sets the pitch
)
(
	input  wire              CLOCK_50,
	input  wire              rstN,
	input  wire              sampleTick,
	input  wire stringCtrl_t stringCtrl,  // Pluck strobe and key level
	input  wire sample_t     noise,       // Shared LFSR word
	output sample_t          voiceOut     // Registered string output
);

	localparam int W = `SAMPLE_WIDTH;

	sample_t               oldSample;     // Tap at the pointer
	sample_t               prevRead;      // Tap from the previous tick
	sample_t               exciteSample;
	sample_t               tapSum;
	sample_t               gain;
	sample_t               filterOut;
	sample_t               nextSample;    // Written back and output
	logic signed [2*W-1:0] product;       // Full-width 2.16 x 2.16
	logic [`PTR_WIDTH-1:0] exciteCount;   // Noise samples still to load
	logic                  active;        // Plucked at least once

	delayLine #(
		.delayLength (delayLength)
	) i_delayLine (
		.CLOCK_50   (CLOCK_50),
		.rstN       (rstN),
		.sampleTick (sampleTick),
		.writeData  (nextSample),
		.readData   (oldSample)
	);

	////////////////////
	// Loss filter
	assign exciteSample = noise >>> `NOISE_SHIFT;  // Scaled burst
	assign gain         = stringCtrl.sustain ? sample_t'(`GAIN_SUSTAIN)
	                                         : sample_t'(`GAIN_DAMP);
	assign tapSum       = oldSample + prevRead;    // Two-point sum
	assign product      = tapSum * gain;
	// Sign bit then integer LSB down to the top fraction bits
	assign filterOut    = {product[2*W-1], product[2*W-4 -: W-1]};

	// Burst first, then the decaying loop, silence before any pluck
	always_comb
	begin
		if (exciteCount != '0)
			nextSample = exciteSample;
		else if (active)
			nextSample = filterOut;
		else
			nextSample = '0;
	end

	////////////////////
	// Control and output state
	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			exciteCount <= '0;
			active      <= 1'b0;
			prevRead    <= '0;
			voiceOut    <= '0;
		end
		else
		begin
			if (stringCtrl.pluck)
			begin
				exciteCount <= `PTR_WIDTH'(delayLength);  // Refill whole line
				active      <= 1'b1;
			end
			else if (sampleTick && exciteCount != '0)
				exciteCount <= exciteCount - 1'b1;

			if (sampleTick)
			begin
				if (exciteCount != '0)
					prevRead <= '0;        // Start the filter clean
				else if (active)
					prevRead <= oldSample;
				voiceOut <= nextSample;    // One cycle after the tick
			end
		end
	end

endmodule

`default_nettype wire

/* logic/voiceMixer.sv */
`default_nettype none

`include "pluckSynth_macros.svh"

module voiceMixer
	import pluckSynthPkg::*;
(
	input  wire                              CLOCK_50,
	input  wire                              rstN,
	input  wire                              sampleTick,
	input  wire sample_t [`NUM_STRINGS-1:0]  voiceOut,   // All string outputs
	output sample_t                          mixSample,
	output logic                             mixValid    // One cycle per mix
);

	localparam int SUM_WIDTH = `SAMPLE_WIDTH + `MIX_SHIFT;  // Room for every voice

	logic                        tickDelay;  // Voices valid in this cycle
	logic signed [SUM_WIDTH-1:0] mixSum;
	logic signed [SUM_WIDTH-1:0] mixScaled;

	// Guarded sum of sign-extended voices
	always_comb
	begin
		mixSum = '0;
		for (int i = 0; i < `NUM_STRINGS; i++)
			mixSum = mixSum + {{`MIX_SHIFT{voiceOut[i][`SAMPLE_WIDTH-1]}}, voiceOut[i]};
	end

	assign mixScaled = mixSum >>> `MIX_SHIFT;  // Back to full-scale range

	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			tickDelay <= 1'b0;
			mixValid  <= 1'b0;
		end
		else
		begin
			tickDelay <= sampleTick;  // Matches voice latency
			mixValid  <= tickDelay;
		end
	end

	// Mixed sample payload
	always_ff @(posedge CLOCK_50)
	begin
		if (tickDelay)
			mixSample <= mixScaled[`SAMPLE_WIDTH-1:0];
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the plucked string testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tbPluckedString -o simTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
	echo "Result: passed"
	exit 0
fi
echo "Result: failed"
exit 1

/* testbench/stringModel.svh */
`ifndef STRINGMODEL_SVH
`define STRINGMODEL_SVH

////////////////////
// Reference model of the string bank, stepped once per tick

localparam int NOTE_LENGTH [`NUM_STRINGS] = '{243, 230, 231, 218, 206, 194, 183, 173};

logic [`SAMPLE_WIDTH-1:0] modelLfsr = `LFSR_SEED;
logic [`NUM_STRINGS-1:0]  modelKeyPrev = '0;    // Key levels at the last tick
int                       modelPtr [`NUM_STRINGS];
int                       modelExcite [`NUM_STRINGS];
bit                       modelActive [`NUM_STRINGS];
sample_t                  modelPrev [`NUM_STRINGS] = '{default: '0};
sample_t                  modelLine [`NUM_STRINGS][256];

// Two-tap average times the loss gain, sign then bits 32 to 16 kept
function automatic sample_t lossFilter(input sample_t a, input sample_t b, input bit held);
	sample_t            tapSum;
	logic signed [35:0] sumWide;
	logic signed [35:0] gainWide;
	logic signed [35:0] wide;
	tapSum   = a + b;
	sumWide  = tapSum;
	gainWide = held ? `GAIN_SUSTAIN : `GAIN_DAMP;  // Positive, zero extended
	wide     = sumWide * gainWide;
	return {wide[35], wide[32:16]};
endfunction

// Advance every string by one sample and return the expected mix
function automatic sample_t modelTick(input logic [`NUM_STRINGS-1:0] keyNow);
	sample_t excite;
	sample_t old;
	sample_t fresh;
	int      mixSum;
	excite = sample_t'(modelLfsr) >>> `NOISE_SHIFT;  // Pre-step noise word
	mixSum = 0;
	for (int i = 0; i < `NUM_STRINGS; i++)
	begin
		if (keyNow[i] && !modelKeyPrev[i])
		begin
			modelExcite[i] = NOTE_LENGTH[i];  // Press restarts the burst
			modelActive[i] = 1'b1;
		end
		old = modelLine[i][modelPtr[i]];
		if (modelExcite[i] > 0)
		begin
			fresh = excite;
			modelExcite[i]--;
			modelPrev[i] = '0;
		end
		else if (modelActive[i])
		begin
			fresh = lossFilter(old, modelPrev[i], keyNow[i]);
			modelPrev[i] = old;
		end
		else
			fresh = '0;  // Never plucked
		modelLine[i][modelPtr[i]] = fresh;
		modelPtr[i] = (modelPtr[i] + 1) % NOTE_LENGTH[i];
		mixSum += fresh;
	end
	modelKeyPrev = keyNow;
	modelLfsr    = {modelLfsr[`SAMPLE_WIDTH-2:0], modelLfsr[17] ^ modelLfsr[10]};
	return sample_t'(mixSum >>> `MIX_SHIFT);  // Low bits of the scaled sum
endfunction

`endif

/* testbench/tbPluckedString.sv */
`default_nettype none

`include "pluckSynth_macros.svh"

module tbPluckedString
	import pluckSynthPkg::*;
();

	localparam int NUM_TICKS   = 3000;
	localparam int MIN_GAP     = 6;    // Idle cycles between ticks
	localparam int MAX_GAP     = 12;
	localparam int RST_CYCLES  = 10;
	localparam int QUIET_TICKS = 40;   // Silent start with no keys
	localparam int PLAN_CYCLES = RST_CYCLES + 4 + NUM_TICKS * (1 + (MIN_GAP + MAX_GAP) / 2);
	localparam int CYCLE_LIMIT = PLAN_CYCLES * 3 / 2;

	logic                    CLOCK_50;
	logic                    rstN;
	logic [`NUM_STRINGS-1:0] keys;
	logic                    sampleTick;
	sample_t                 mixSample;
	logic                    mixValid;

	logic [1:0] tickHist = '0;     // Ticks seen at the last two edges
	int         cycleCount = 0;
	sample_t    expectQ [$];       // Model results waiting for mixValid

	`include "stringModel.svh"

	pluckedStringSynth i_dut (
		.CLOCK_50   (CLOCK_50),
		.rstN       (rstN),
		.keys       (keys),
		.sampleTick (sampleTick),
		.mixSample  (mixSample),
		.mixValid   (mixValid)
	);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #2 CLOCK_50 = ~CLOCK_50;
	end

	task automatic compareValue(input string name, input logic signed [31:0] actual,
		input logic signed [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAIL time=%0t %s got=%0d expected=%0d", $time, name, actual, expected);
			$display("=== FAIL ===");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	////////////////////
	// Monitor sees values from before the edge updates
	always @(posedge CLOCK_50)
	begin
		cycleCount++;
		if (cycleCount > CYCLE_LIMIT)
		begin
			$display("Timeout: the run passed %0d cycles", CYCLE_LIMIT);
			$display("=== FAIL ===");
			$fatal(1, "Timeout");
		end
		if (rstN)
		begin
			compareValue("mixValid", mixValid, tickHist[1]);  // Exactly 2 cycles late
			if (mixValid)
				compareValue("mixSample", mixSample, expectQ.pop_front());
			if (sampleTick)
				expectQ.push_back(modelTick(keys));  // Keys settled long before
			tickHist = {tickHist[0], sampleTick};
		end
	end

	// One tick, wait for its mix, then maybe change keys
	task automatic sendTick(input int tickIndex);
		int gap;
		int waited;
		gap = MIN_GAP + ($urandom % (MAX_GAP - MIN_GAP + 1));
		sampleTick <= 1'b1;
		@(posedge CLOCK_50);
		sampleTick <= 1'b0;
		waited = 0;
		do
		begin
			@(posedge CLOCK_50);
			waited++;
			if (waited > MIN_GAP - 2)
			begin
				$display("mixValid never arrived after tick %0d", tickIndex);
				$display("=== FAIL ===");
				$fatal(1, "Missing mixValid");
			end
		end
		while (!mixValid);
		// Rare toggles so strings ring through many passes
		if (tickIndex >= QUIET_TICKS && $urandom_range(39, 0) == 0)
			keys <= keys ^ (`NUM_STRINGS'(1) << $urandom_range(`NUM_STRINGS - 1, 0));
		repeat (gap - waited) @(posedge CLOCK_50);
	endtask

	////////////////////
	// Stimulus and verdict
	initial
	begin
		void'($urandom(32'hb51d6962));
		rstN       = 1'b0;
		keys       = '0;
		sampleTick = 1'b0;
		repeat (RST_CYCLES) @(posedge CLOCK_50);
		rstN <= 1'b1;
		repeat (4) @(posedge CLOCK_50);
		for (int t = 0; t < NUM_TICKS; t++)
			sendTick(t);
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire
